//--- hdl/rx_cfg_pkg.sv
//**********************************************************
// Receive lane configuration constants
// Word width, delay line size and PLL lock wait count
//**********************************************************

package rx_cfg_pkg;

    //**********************************************************
    // Deserializer
    //**********************************************************

    localparam int DESER_WIDTH    = 4;                    // Bits per word
    localparam int DESER_CNT_BITS = $clog2(DESER_WIDTH);  // Bit counter width

    //**********************************************************
    // Input delay line
    //**********************************************************

    // One fabric cycle per tap, tap 0 is the shortest path
    localparam int DLY_TAPS     = 8;                      // Number of taps
    localparam int DLY_TAP_BITS = $clog2(DLY_TAPS);       // Tap index width

    //**********************************************************
    // PLL lock wait
    //**********************************************************

    // Lane stays not ready until lock has been stable this long
    localparam int LOCK_WAIT     = 255;                   // Stable lock cycles
    localparam int LOCK_CNT_BITS = 8;                     // Lock counter width

endpackage

//--- hdl/rx_types_pkg.sv
//**********************************************************
// Receive lane signal bundles
// Delay line control and deserialized word types
//**********************************************************

package rx_types_pkg;

    import rx_cfg_pkg::*;

    //**********************************************************
    // Delay line control
    //**********************************************************

    // Load wins over adj when both pulse in the same cycle
    typedef struct packed {
        logic                    load;       // Pulse, load tap_value
        logic                    adj;        // Pulse, step tap by one
        logic                    incdec;     // 1 steps up, 0 steps down
        logic [DLY_TAP_BITS-1:0] tap_value;  // Tap for load
    } dly_ctrl_t;

    //**********************************************************
    // Deserialized word
    //**********************************************************

    // First received bit sits in the MSB of data
    typedef struct packed {
        logic [DESER_WIDTH-1:0] data;        // Completed word
        logic                   valid;       // One-cycle word pulse
    } deser_word_t;

endpackage

//--- hdl/rx_input_delay.sv
//**********************************************************
// Receive input delay line
// Delays the serial bit by a programmable number of taps,
// set by a load or stepped by saturating adjust pulses
//**********************************************************
`timescale 1ns/100ps

module rx_input_delay (
    input  logic                    fabric_clk_div,  // Fabric clock
    input  logic                    reset_buf_n,     // Async reset, active low
    input  logic                    data_i,          // Serial bit in
    input  rx_types_pkg::dly_ctrl_t dly_ctrl,        // Load and step controls
    output logic                    dly_bit          // Delayed serial bit
);

    import rx_cfg_pkg::*;

    logic [DLY_TAP_BITS-1:0] tap_q;    // Current tap index
    logic [DLY_TAPS-2:0]     hist_q;   // Past bits, bit 0 newest
    logic [DLY_TAPS-1:0]     window;   // Current bit plus history
    logic                    at_max;   // Tap at top end
    logic                    at_min;   // Tap at zero

    assign window = {hist_q, data_i};  // window[k] is data_i k cycles back
    assign at_max = (tap_q == DLY_TAP_BITS'(DLY_TAPS - 1));
    assign at_min = (tap_q == '0);

    //**********************************************************
    // Tap control
    //**********************************************************

    always_ff @(posedge fabric_clk_div or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            tap_q <= '0;                               // Shortest path
        end else if (dly_ctrl.load) begin
            tap_q <= dly_ctrl.tap_value;               // Load has priority
        end else if (dly_ctrl.adj) begin
            if (dly_ctrl.incdec && !at_max) begin
                tap_q <= tap_q + 1'b1;                 // Step up
            end else if (!dly_ctrl.incdec && !at_min) begin
                tap_q <= tap_q - 1'b1;                 // Step down
            end
        end
    end

    //**********************************************************
    // Bit history and tap select
    //**********************************************************

    always_ff @(posedge fabric_clk_div) begin
        hist_q <= window[DLY_TAPS-2:0];                // Shift one bit older
    end

    // Output register adds the fixed one-cycle base delay
    always_ff @(posedge fabric_clk_div or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            dly_bit <= 1'b0;
        end else begin
            dly_bit <= window[tap_q];                  // Pick by current tap
        end
    end

endmodule

//--- hdl/rx_deserializer.sv
//**********************************************************
// Receive deserializer
// Shifts serial bits into words, first bit in the MSB, with
// enable gating and a bitslip that delays the word boundary
//**********************************************************
`timescale 1ns/100ps

module rx_deserializer (
    input  logic                      fabric_clk_div,  // Fabric clock
    input  logic                      reset_buf_n,     // Async reset, active low
    input  logic                      dly_bit,         // Serial bit from delay
    input  logic                      enable_n,        // High forces zeros in
    input  logic                      bitslip,         // Pulse, hold bit counter
    output rx_types_pkg::deser_word_t deser_word       // Word with valid pulse
);

    import rx_cfg_pkg::*;

    logic [DESER_CNT_BITS-1:0] bit_cnt_q;   // Position within word
    logic [DESER_WIDTH-1:0]    shift_q;     // Bits gathered so far
    logic [DESER_WIDTH-1:0]    shift_d;     // Shift with this cycle's bit
    logic [DESER_WIDTH-1:0]    word_q;      // Last completed word
    logic                      valid_q;     // Word pulse
    logic                      gated_bit;   // Input after enable gate
    logic                      last_bit;    // Counter at last position
    logic                      word_end;    // Word completes this cycle

    assign gated_bit = dly_bit & ~enable_n;                 // Zero while disabled
    assign shift_d   = {shift_q[DESER_WIDTH-2:0], gated_bit};
    assign last_bit  = (bit_cnt_q == DESER_CNT_BITS'(DESER_WIDTH - 1));
    assign word_end  = last_bit & ~bitslip;                 // Slip defers the end

    //**********************************************************
    // Bit counter with bitslip hold
    //**********************************************************

    always_ff @(posedge fabric_clk_div or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            bit_cnt_q <= '0;
        end else if (bitslip) begin
            bit_cnt_q <= bit_cnt_q;                         // Hold one cycle
        end else if (last_bit) begin
            bit_cnt_q <= '0;                                // Wrap
        end else begin
            bit_cnt_q <= bit_cnt_q + 1'b1;
        end
    end

    //**********************************************************
    // Shift register and word output
    //**********************************************************

    // Shifts every cycle, also during a slip
    always_ff @(posedge fabric_clk_div) begin
        shift_q <= shift_d;
    end

    always_ff @(posedge fabric_clk_div) begin
        if (word_end) begin
            word_q <= shift_d;                              // Include last bit
        end
    end

    always_ff @(posedge fabric_clk_div or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= word_end;                            // One cycle per word
        end
    end

    assign deser_word.data  = word_q;
    assign deser_word.valid = valid_q;

endmodule

//--- hdl/rx_lock_timer.sv
//**********************************************************
// Receive lock timer
// Counts stable PLL lock cycles and raises lane ready
//**********************************************************
`timescale 1ns/100ps

module rx_lock_timer (
    input  logic fabric_clk_div,  // Fabric clock
    input  logic reset_buf_n,     // Async reset, active low
    input  logic pll_lock,        // PLL lock level
    output logic ready            // Lane ready level
);

    import rx_cfg_pkg::*;

    logic [LOCK_CNT_BITS-1:0] lock_cnt_q;  // Stable lock cycles
    logic [LOCK_CNT_BITS-1:0] lock_cnt_d;  // Next count
    logic                     lock_done;   // Count at LOCK_WAIT

    assign lock_done = (lock_cnt_q == LOCK_CNT_BITS'(LOCK_WAIT));

    always_comb begin
        if (!pll_lock) begin
            lock_cnt_d = '0;                          // Lock lost, restart
        end else if (lock_done) begin
            lock_cnt_d = lock_cnt_q;                  // Saturate
        end else begin
            lock_cnt_d = lock_cnt_q + 1'b1;
        end
    end

    // Ready tracks the registered count, same edge
    always_ff @(posedge fabric_clk_div or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            lock_cnt_q <= '0;
            ready      <= 1'b0;
        end else begin
            lock_cnt_q <= lock_cnt_d;
            ready      <= (lock_cnt_d == LOCK_CNT_BITS'(LOCK_WAIT));
        end
    end

endmodule

//--- hdl/rx_word_capture.sv
//**********************************************************
// Receive word capture
// Holds the last word accepted while the lane is ready and
// pulses a strobe for each accepted word
//**********************************************************
`timescale 1ns/100ps

module rx_word_capture (
    input  logic                                fabric_clk_div,  // Fabric clock
    input  logic                                reset_buf_n,     // Async reset
    input  rx_types_pkg::deser_word_t           deser_word,      // Word and valid
    input  logic                                ready,           // Lane ready
    output logic [rx_cfg_pkg::DESER_WIDTH-1:0]  data_o,          // Captured word
    output logic                                word_strobe      // New word pulse
);

    logic accept;  // Valid word while ready

    // Words that arrive before ready are dropped
    assign accept = deser_word.valid & ready;

    always_ff @(posedge fabric_clk_div or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            data_o <= '0;
        end else if (accept) begin
            data_o <= deser_word.data;                // Else hold last word
        end
    end

    always_ff @(posedge fabric_clk_div or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            word_strobe <= 1'b0;
        end else begin
            word_strobe <= accept;                    // Aligned with data_o
        end
    end

endmodule

//--- hdl/rx_lane_top.sv
//**********************************************************
// Receive lane top level
// Delay line, deserializer, lock timer and word capture on
// one fabric clock
//**********************************************************
`timescale 1ns/100ps

module rx_lane_top (
    input  logic                                fabric_clk_div,  // Fabric clock
    input  logic                                reset_buf_n,     // Async reset
    input  logic                                data_i,          // Serial bit in
    input  logic                                enable_n,        // Gate input low
    input  logic                                bitslip,         // Slip pulse
    input  logic                                pll_lock,        // PLL lock level
    input  rx_types_pkg::dly_ctrl_t             dly_ctrl,        // Delay controls
    output logic [rx_cfg_pkg::DESER_WIDTH-1:0]  data_o,          // Captured word
    output logic                                word_strobe,     // New word pulse
    output logic                                ready            // Lane ready
);

    import rx_types_pkg::*;

    logic        dly_bit;     // Delayed serial bit
    deser_word_t deser_word;  // Deserializer output

    //**********************************************************
    // Serial path
    //**********************************************************

    rx_input_delay i_input_delay (
        .fabric_clk_div (fabric_clk_div),
        .reset_buf_n    (reset_buf_n),
        .data_i         (data_i),
        .dly_ctrl       (dly_ctrl),
        .dly_bit        (dly_bit)
    );

    rx_deserializer i_deserializer (
        .fabric_clk_div (fabric_clk_div),
        .reset_buf_n    (reset_buf_n),
        .dly_bit        (dly_bit),
        .enable_n       (enable_n),
        .bitslip        (bitslip),
        .deser_word     (deser_word)
    );

    //**********************************************************
    // Lock wait and capture
    //**********************************************************

    rx_lock_timer i_lock_timer (
        .fabric_clk_div (fabric_clk_div),
        .reset_buf_n    (reset_buf_n),
        .pll_lock       (pll_lock),
        .ready          (ready)
    );

    rx_word_capture i_word_capture (
        .fabric_clk_div (fabric_clk_div),
        .reset_buf_n    (reset_buf_n),
        .deser_word     (deser_word),
        .ready          (ready),         // Also the top output
        .data_o         (data_o),
        .word_strobe    (word_strobe)
    );

endmodule

//--- verif/rx_lane_tb.sv
//**********************************************************
// Receive lane testbench
// Random serial stream with lock, delay, bitslip and gating
// stimulus, checked each cycle against a model of the lane
//**********************************************************
`timescale 1ns/100ps

module rx_lane_tb;

    import rx_cfg_pkg::*;
    import rx_types_pkg::*;

    logic                   fabric_clk_div;   // Fabric clock
    logic                   reset_buf_n;      // Async active-low reset
    logic                   data_i;           // Serial bit
    logic                   enable_n;         // Input gate
    logic                   bitslip;          // Slip pulse
    logic                   pll_lock;         // Lock level
    dly_ctrl_t              dly_ctrl;         // Delay pulses
    logic [DESER_WIDTH-1:0] data_o;           // Captured word
    logic                   word_strobe;      // Word pulse
    logic                   ready;            // Lane ready

    logic                   lock_lvl;         // Lock level to drive
    logic                   gate_lvl;         // enable_n level to drive
    logic                   latency_on;       // Direct word check active
    logic                   prev_ready;       // ready one cycle back

    //**********************************************************
    // Model state
    //**********************************************************

    logic                   sent_q [$];       // Every driven data_i bit
    int                     m_tap;            // Tap index
    int                     tap_age;          // Cycles since tap changed
    logic                   m_dly;            // Delay line output
    int                     m_bit_pos;        // Position within word
    logic [DESER_WIDTH-1:0] m_shift;
    logic [DESER_WIDTH-1:0] m_word;
    logic                   m_valid;
    int                     m_lock_cnt;
    logic                   m_ready;
    logic [DESER_WIDTH-1:0] m_data;
    logic                   m_strobe;

    int checks       = 0;
    int errors       = 0;
    int err_start    = 0;                     // Errors before current test
    int last_strobe  = -1;                    // Cycle of last strobe
    int long_gaps    = 0;                     // Strobe gaps of five
    int bad_gaps     = 0;                     // Gaps neither four nor five
    int latency_hits = 0;                     // Words checked from history

    rx_lane_top i_dut (
        .fabric_clk_div (fabric_clk_div),
        .reset_buf_n    (reset_buf_n),
        .data_i         (data_i),
        .enable_n       (enable_n),
        .bitslip        (bitslip),
        .pll_lock       (pll_lock),
        .dly_ctrl       (dly_ctrl),
        .data_o         (data_o),
        .word_strobe    (word_strobe),
        .ready          (ready)
    );

    always #4 fabric_clk_div = ~fabric_clk_div;  // 8 ns period

    task automatic compare(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0d ns: %s, got %0h, expected %0h",
                     $time, what, got, exp);
        end
    endtask

    task automatic clear_model;
        sent_q.delete();
        m_tap      = 0;
        tap_age    = 0;
        m_dly      = 1'b0;
        m_bit_pos  = 0;
        m_shift    = '0;
        m_word     = '0;
        m_valid    = 1'b0;
        m_lock_cnt = 0;
        m_ready    = 1'b0;
        m_data     = '0;
        m_strobe   = 1'b0;
        prev_ready = 1'b0;
    endtask

    //**********************************************************
    // Cycle model run once per rising edge with downstream first
    //**********************************************************

    task automatic advance_model;
        int   idx;
        int   old_tap;
        logic gated;
        sent_q.push_back(data_i);
        m_strobe = m_valid & m_ready;                   // Accept uses old state
        if (m_strobe) begin
            m_data = m_word;
        end
        if (!pll_lock) begin
            m_lock_cnt = 0;                             // Lock loss restarts
        end else if (m_lock_cnt < LOCK_WAIT) begin
            m_lock_cnt++;
        end
        m_ready = (m_lock_cnt == LOCK_WAIT);
        gated   = m_dly & ~enable_n;                    // Zero while gated
        m_shift = {m_shift[DESER_WIDTH-2:0], gated};    // First bit ends in MSB
        m_valid = (m_bit_pos == DESER_WIDTH - 1) && !bitslip;
        if (m_valid) begin
            m_word = m_shift;
        end
        if (!bitslip) begin
            m_bit_pos = (m_bit_pos + 1) % DESER_WIDTH;  // Slip holds position
        end
        idx   = sent_q.size() - 1 - m_tap;              // data_i tap cycles back
        m_dly = (idx >= 0) ? sent_q[idx] : 1'b0;
        old_tap = m_tap;
        if (dly_ctrl.load) begin
            m_tap = int'(dly_ctrl.tap_value);           // Load beats adj
        end else if (dly_ctrl.adj) begin
            if (dly_ctrl.incdec && m_tap < DLY_TAPS - 1) begin
                m_tap++;
            end else if (!dly_ctrl.incdec && m_tap > 0) begin
                m_tap--;
            end
        end
        tap_age = (m_tap == old_tap) ? tap_age + 1 : 0;
    endtask

    task automatic check_outputs;
        int                     base;
        int                     gap;
        int                     b;
        logic [DESER_WIDTH-1:0] exp_word;
        compare(32'(data_o), 32'(m_data), "data_o against model");
        compare(32'(word_strobe), 32'(m_strobe), "word_strobe against model");
        compare(32'(ready), 32'(m_ready), "ready against model");
        compare(32'(word_strobe & ~prev_ready), 0, "word_strobe while ready low");
        if (word_strobe) begin
            if (last_strobe >= 0) begin
                gap = sent_q.size() - last_strobe;
                if (gap == DESER_WIDTH + 1) begin
                    long_gaps++;
                end else if (gap != DESER_WIDTH) begin
                    bad_gaps++;
                end
            end
            last_strobe = sent_q.size();
            // Last bit of the word left data_i 1 + tap + 1 + 1 cycles ago
            if (latency_on && tap_age >= 10) begin
                base = sent_q.size() - 3 - m_tap;
                for (b = 0; b < DESER_WIDTH; b++) begin
                    exp_word[b] = sent_q[base - b];
                end
                compare(32'(data_o), 32'(exp_word), "word from serial history");
                latency_hits++;
            end
        end
        prev_ready = ready;
    endtask

    // Check at the falling edge and then drive the next inputs
    task automatic step(input logic slip, input dly_ctrl_t ctrl);
        @(negedge fabric_clk_div);
        check_outputs();
        data_i   = 1'($urandom);
        bitslip  = slip;
        dly_ctrl = ctrl;
        pll_lock = lock_lvl;
        enable_n = gate_lvl;
        advance_model();
    endtask

    task automatic wait_ready(output int n);
        n = 0;
        step(1'b0, '0);
        while (!ready && n < LOCK_WAIT + 40) begin
            n++;
            step(1'b0, '0);
        end
        if (!ready) begin
            errors++;
            $display("Timeout: ready stayed low for %0d cycles after pll_lock rose", n);
        end
    endtask

    task automatic begin_test;
        err_start   = errors;
        last_strobe = -1;
        long_gaps   = 0;
        bad_gaps    = 0;
    endtask

    task automatic end_test(input string name);
        $display("Test %-16s done, %0d errors", name, errors - err_start);
    endtask

    //**********************************************************
    // Tests
    //**********************************************************

    task automatic reset_sequence;
        begin_test();
        repeat (3) begin
            @(negedge fabric_clk_div);
            compare(32'(data_o), 0, "data_o in reset");
            compare(32'(word_strobe), 0, "word_strobe in reset");
            compare(32'(ready), 0, "ready in reset");
        end
        reset_buf_n = 1'b1;                             // Released on a falling edge
        advance_model();
        repeat (4) step(1'b0, '0);
        end_test("reset state");
    endtask

    task automatic lock_wait_sequence;
        int n;
        begin_test();
        repeat (3) begin
            lock_lvl = 1'b1;                            // Burst too short for ready
            repeat ($urandom_range(1, LOCK_WAIT - 10)) step(1'b0, '0);
            lock_lvl = 1'b0;
            repeat ($urandom_range(1, 3)) step(1'b0, '0);
            lock_lvl = 1'b1;
            wait_ready(n);
            compare(n, LOCK_WAIT, "cycles from pll_lock to ready");
            repeat ($urandom_range(5, 40)) step(1'b0, '0);
            lock_lvl = 1'b0;
            step(1'b0, '0);
            compare(32'(ready), 1, "ready in the cycle lock drops");
            step(1'b0, '0);
            compare(32'(ready), 0, "ready the cycle after lock drop");
        end
        lock_lvl = 1'b1;
        wait_ready(n);
        compare(n, LOCK_WAIT, "cycles from pll_lock to ready");
        end_test("lock wait");
    endtask

    task automatic tap0_stream;
        int hits;
        begin_test();
        latency_on = 1'b1;
        hits       = latency_hits;
        repeat (400) step(1'b0, '0);
        compare(long_gaps + bad_gaps, 0, "strobe spacing at tap 0");
        compare(32'(latency_hits > hits), 1, "words checked at tap 0");
        end_test("stream tap 0");
    endtask

    task automatic delay_control_sweep;
        dly_ctrl_t ctrl;
        int        hits;
        begin_test();
        repeat (40) begin
            ctrl.load      = 1'($urandom);
            ctrl.adj       = 1'($urandom);
            ctrl.incdec    = 1'($urandom);
            ctrl.tap_value = DLY_TAP_BITS'($urandom);
            step(1'b0, ctrl);
            repeat ($urandom_range(0, 24)) step(1'b0, '0);
        end
        // Steps past the top end must stick at the last tap
        ctrl           = '0;
        ctrl.load      = 1'b1;
        ctrl.tap_value = DLY_TAP_BITS'(DLY_TAPS - 1);
        step(1'b0, ctrl);
        ctrl        = '0;
        ctrl.adj    = 1'b1;
        ctrl.incdec = 1'b1;
        repeat (3) begin
            step(1'b0, ctrl);
            step(1'b0, '0);
        end
        hits = latency_hits;
        repeat (40) step(1'b0, '0);
        compare(32'(latency_hits > hits), 1, "words checked at top tap");
        // And below zero at the bottom end
        ctrl      = '0;
        ctrl.load = 1'b1;
        step(1'b0, ctrl);
        ctrl     = '0;
        ctrl.adj = 1'b1;
        repeat (3) begin
            step(1'b0, ctrl);
            step(1'b0, '0);
        end
        hits = latency_hits;
        repeat (40) step(1'b0, '0);
        compare(32'(latency_hits > hits), 1, "words checked at bottom tap");
        end_test("delay control");
    endtask

    task automatic bitslip_sweep;
        int slips;
        begin_test();
        latency_on = 1'b0;
        slips      = 0;
        repeat (12) begin
            repeat ($urandom_range(10, 30)) step(1'b0, '0);
            step(1'b1, '0);                             // One slip per word at most
            slips++;
        end
        repeat (20) step(1'b0, '0);
        compare(long_gaps, slips, "five-cycle strobe gaps against bitslips");
        compare(bad_gaps, 0, "other strobe gaps during bitslip");
        end_test("bitslip");
    endtask

    task automatic enable_gating_sweep;
        begin_test();
        gate_lvl = 1'b1;
        repeat (12) step(1'b0, '0);
        compare(32'(data_o), 0, "word captured while fully gated");
        repeat (10) begin
            gate_lvl = 1'($urandom);
            repeat ($urandom_range(3, 20)) step(1'b0, '0);
        end
        gate_lvl = 1'b0;
        repeat (12) step(1'b0, '0);
        compare(long_gaps + bad_gaps, 0, "strobe spacing under enable gating");
        end_test("enable gating");
    endtask

    initial begin
        void'($urandom(53881));                         // Fixed seed
        fabric_clk_div = 1'b0;
        reset_buf_n    = 1'b0;
        data_i         = 1'b0;
        enable_n       = 1'b0;
        bitslip        = 1'b0;
        pll_lock       = 1'b0;
        dly_ctrl       = '0;
        lock_lvl       = 1'b0;
        gate_lvl       = 1'b0;
        latency_on     = 1'b0;
        clear_model();
        reset_sequence();
        lock_wait_sequence();
        tap0_stream();
        delay_control_sweep();
        bitslip_sweep();
        enable_gating_sweep();
        $display("Summary: %0d checks run, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- serdes_rx_lane.f
hdl/rx_cfg_pkg.sv
hdl/rx_types_pkg.sv
hdl/rx_input_delay.sv
hdl/rx_deserializer.sv
hdl/rx_lock_timer.sv
hdl/rx_word_capture.sv
hdl/rx_lane_top.sv
verif/rx_lane_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the receive lane testbench with Verilator and run it.
# The run counts as passed only when the testbench prints its pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 \
    --timescale 1ns/100ps \
    --top-module rx_lane_tb \
    -f serdes_rx_lane.f \
    -o rx_lane_sim \
&& ./obj_dir/rx_lane_sim | tee /dev/stderr | grep -q "TESTBENCH PASSED" \
&& echo "run_sim: simulation passed" \
|| { echo "run_sim: simulation failed"; exit 1; }
